// ==== Makefile ====
# Verilator build and run of the credit flow ALU pipeline testbench

VERILATOR ?= verilator
TOP       ?= aluPipeTb
FLAGS     ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f

.PHONY: sim clean

# a $fatal in the testbench makes the run return a failing status
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/aluTbModel.svh ====
// alu testbench helpers, reference model, lfsr step and opcode picker
`ifndef ALU_TB_MODEL_SVH
`define ALU_TB_MODEL_SVH

localparam int TOP_BIT = aluPkg::WORD_WIDTH - 1;

// expected response straight from the arithmetic and bitwise rules
function automatic aluPkg::aluResp_t modelAlu(input aluPkg::aluOp_t op,
                                             input aluPkg::word_t  a,
                                             input aluPkg::word_t  b);
    logic [aluPkg::WORD_WIDTH:0] wide;
    aluPkg::aluResp_t            resp;
    resp = '0;
    case (op)
        aluPkg::OP_ADD: begin
            wide          = {1'b0, a} + {1'b0, b};
            resp.result   = wide[TOP_BIT:0];
            resp.carryout = wide[aluPkg::WORD_WIDTH];
            resp.overflow = (a[TOP_BIT] == b[TOP_BIT]) && (resp.result[TOP_BIT] != a[TOP_BIT]);
        end
        aluPkg::OP_SUB: begin
            wide          = {1'b0, a} + {1'b0, ~b} + 33'd1;  // a + not b + 1
            resp.result   = wide[TOP_BIT:0];
            resp.carryout = wide[aluPkg::WORD_WIDTH];
            // addends are a and not b
            resp.overflow = (a[TOP_BIT] == ~b[TOP_BIT]) && (resp.result[TOP_BIT] != a[TOP_BIT]);
        end
        aluPkg::OP_XOR:  resp.result = a ^ b;
        aluPkg::OP_SLT:  resp.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        aluPkg::OP_AND:  resp.result = a & b;
        aluPkg::OP_NAND: resp.result = ~(a & b);
        aluPkg::OP_NOR:  resp.result = ~(a | b);
        default:         resp.result = a | b;  // or
    endcase
    resp.zero = (resp.result == '0);
    return resp;
endfunction

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

// half the picks lean on the adder ops, where carry and overflow live
function automatic aluPkg::aluOp_t pickOp(input logic [3:0] bits);
    if (bits[3]) begin
        return aluPkg::aluOp_t'({1'b0, bits[1:0]});
    end
    return aluPkg::aluOp_t'(bits[2:0]);
endfunction

`endif

// ==== sim/aluPipeTb.sv ====
// credit flow alu pipeline testbench with lfsr stimulus, scoreboard and assertions
`timescale 1ns/1ps
`default_nettype none

module aluPipeTb;

    `include "aluTbModel.svh"

    localparam int CLK_HALF      = 20;
    localparam int DRIVE_DELAY   = 2;   // inputs change this long after the rising edge
    localparam int RANDOM_COUNT  = 400;
    localparam int SEND_TIMEOUT  = 200;
    localparam int DRAIN_TIMEOUT = 600;

    logic             clk;
    logic             rstN;
    logic             inValid;
    aluPkg::aluReq_t  inReq;
    logic             outCreditReturn;
    logic             inCredit;
    logic             outValid;
    aluPkg::aluResp_t outResp;

    logic [31:0]      lfsrState;
    aluPkg::aluResp_t expectedQ [$];  // model responses in request order
    logic             resetApplied;
    int               upstreamCredits;
    int               grantsSeen;
    int               resultsDelivered;
    int               creditsReturned;
    int               unreturned;       // delivered results whose slot is still held
    int               holdCycles;       // downstream withholds credits while nonzero
    int               zeroSeen;
    int               starvedCycles;

    aluPipe u_dut (
        .clk             (clk),
        .rstN            (rstN),
        .inValid         (inValid),
        .inReq           (inReq),
        .outCreditReturn (outCreditReturn),
        .inCredit        (inCredit),
        .outValid        (outValid),
        .outResp         (outResp)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic stopRun();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic reportMismatch(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        stopRun();
    endtask

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        stopRun();
    endtask

    task automatic takeBits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits      = {bits[30:0], lfsrState[0]};
        end
    endtask

    // outputs here reflect the edge that just passed
    task automatic collectOutputs();
        aluPkg::aluResp_t expected;
        if (inCredit) begin
            upstreamCredits++;
            grantsSeen++;
        end
        if (outValid) begin
            resultsDelivered++;
            unreturned++;
            assert (expectedQ.size() > 0)
                else reportFailure("a result came out with no request outstanding");
            expected = expectedQ.pop_front();
            assert (outResp === expected)
                else reportMismatch($sformatf("got %h c%b v%b z%b, expected %h c%b v%b z%b",
                    outResp.result, outResp.carryout, outResp.overflow, outResp.zero,
                    expected.result, expected.carryout, expected.overflow, expected.zero));
            if (outResp.zero) begin
                zeroSeen++;
            end
        end
    endtask

    // downstream frees slots at random, with stretches of no credits at all
    task automatic driveCreditReturn();
        logic [31:0] bits;
        outCreditReturn = 1'b0;
        if (holdCycles > 0) begin
            holdCycles--;
        end else begin
            takeBits(4, bits);
            if (bits[3:0] == 4'd0) begin
                takeBits(5, bits);
                holdCycles = 8 + int'(bits[4:0]);
            end else begin
                takeBits(1, bits);
                if (unreturned > 0 && bits[0]) begin
                    outCreditReturn = 1'b1;
                    unreturned--;
                    creditsReturned++;
                end
            end
        end
    endtask

    task automatic stepCycle(input logic wantSend, input aluPkg::aluReq_t req, output logic sent);
        @(posedge clk);
        #DRIVE_DELAY;
        collectOutputs();
        driveCreditReturn();
        sent = 1'b0;
        if (wantSend && upstreamCredits > 0) begin
            inValid = 1'b1;
            inReq   = req;
            upstreamCredits--;
            expectedQ.push_back(modelAlu(req.command, req.operandA, req.operandB));
            sent = 1'b1;
        end else begin
            inValid = 1'b0;
            if (wantSend) begin
                starvedCycles++;
            end
        end
    endtask

    task automatic idleCycle();
        logic sent;
        stepCycle(1'b0, '0, sent);
    endtask

    task automatic sendRequest(input aluPkg::aluOp_t op, input aluPkg::word_t a,
                               input aluPkg::word_t b);
        aluPkg::aluReq_t req;
        logic            sent;
        int              waited;
        req.command  = op;
        req.operandA = a;
        req.operandB = b;
        sent         = 1'b0;
        waited       = 0;
        while (!sent && waited < SEND_TIMEOUT) begin
            stepCycle(1'b1, req, sent);
            waited++;
        end
        if (!sent) begin
            reportFailure("timed out waiting for an input credit");
        end
    endtask

    resetQuiet: assert property (
        @(posedge clk) (resetApplied && $past(!rstN)) |-> (!inCredit && !outValid)
    ) else reportFailure("inCredit or outValid high during reset or the cycle after it");

    inCreditsBounded: assert property (
        @(posedge clk) grantsSeen <= resultsDelivered + aluPkg::QUEUE_DEPTH
    ) else reportFailure("more input credits granted than the queue can hold");

    outValidBounded: assert property (
        @(posedge clk) resultsDelivered <= creditsReturned + aluPkg::OUT_CREDITS
    ) else reportFailure("results delivered beyond the output credits granted");

    initial begin
        logic [31:0]    bits;
        aluPkg::aluOp_t op;
        aluPkg::word_t  a;
        aluPkg::word_t  b;
        int             waited;
        rstN             = 1'b0;
        inValid          = 1'b0;
        inReq            = '0;
        outCreditReturn  = 1'b0;
        lfsrState        = 32'h226b_0f80;
        resetApplied     = 1'b0;
        upstreamCredits  = 0;
        grantsSeen       = 0;
        resultsDelivered = 0;
        creditsReturned  = 0;
        unreturned       = 0;
        holdCycles       = 24;  // downstream starts out stalled
        zeroSeen         = 0;
        starvedCycles    = 0;

        @(posedge clk);
        #DRIVE_DELAY;
        resetApplied = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        rstN = 1'b1;

        // equal operands give a zero result
        sendRequest(aluPkg::OP_SUB, 32'h1234_5678, 32'h1234_5678);
        sendRequest(aluPkg::OP_XOR, 32'hdead_beef, 32'hdead_beef);
        sendRequest(aluPkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
        sendRequest(aluPkg::OP_ADD, 32'h8000_0000, 32'h8000_0000);
        sendRequest(aluPkg::OP_SUB, 32'h8000_0000, 32'h0000_0001);
        sendRequest(aluPkg::OP_SUB, 32'h7fff_ffff, 32'hffff_ffff);
        sendRequest(aluPkg::OP_SLT, 32'hffff_ffff, 32'h0000_0000);
        sendRequest(aluPkg::OP_SLT, 32'h0000_0000, 32'hffff_ffff);

        for (int i = 0; i < RANDOM_COUNT; i++) begin
            takeBits(4, bits);
            op = pickOp(bits[3:0]);
            takeBits(32, bits);
            a = bits;
            takeBits(2, bits);
            if (bits[1:0] == 2'd0) begin
                b = a;
            end else begin
                takeBits(32, bits);
                b = bits;
            end
            takeBits(2, bits);
            if (bits[1:0] == 2'd0) begin
                idleCycle();
            end
            sendRequest(op, a, b);
        end

        waited = 0;
        while (expectedQ.size() > 0 && waited < DRAIN_TIMEOUT) begin
            idleCycle();
            waited++;
        end

        if (expectedQ.size() > 0) begin
            reportFailure("timed out waiting for outstanding results");
        end else if (zeroSeen == 0) begin
            reportFailure("zero flag was never set on a result");
        end else if (starvedCycles == 0) begin
            reportFailure("output credit stalls never held back the input side");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+sim
verilog/aluPkg.sv
verilog/aluOperandStage.sv
verilog/aluExecuteStage.sv
verilog/aluResultQueue.sv
verilog/aluPipe.sv
sim/aluPipeTb.sv

// ==== verilog/aluExecuteStage.sv ====
// alu stage two, adder, xor, slt, nand and nor units with result select and flags
`timescale 1ns/1ps
`default_nettype none

module aluExecuteStage (
    input  wire logic               clk,
    input  wire logic               rstN,
    input  wire logic               s1Valid,
    input  wire aluPkg::aluStage1_t s1Data,
    output logic                    s2Valid,
    output aluPkg::aluResp_t        s2Resp
);

    logic [aluPkg::WORD_WIDTH:0] adderFull;   // sum with carry out on top
    aluPkg::word_t               lowPart;     // msb holds the carry into bit 31
    aluPkg::word_t               adderSum;
    logic                        adderCarry;
    logic                        carryIntoMsb;
    logic                        adderOverflow;
    aluPkg::word_t               xorOut;
    aluPkg::word_t               sltOut;
    aluPkg::word_t               nandOut;
    aluPkg::word_t               norOut;
    aluPkg::word_t               result;
    logic                        useAdder;

    // invB is the carry-in, so sub and slt get a true two's complement difference
    assign adderFull = {1'b0, s1Data.inputA} + {1'b0, s1Data.inputB}
                     + {{aluPkg::WORD_WIDTH{1'b0}}, s1Data.invB};
    assign lowPart   = {1'b0, s1Data.inputA[aluPkg::WORD_WIDTH-2:0]}
                     + {1'b0, s1Data.inputB[aluPkg::WORD_WIDTH-2:0]}
                     + {{(aluPkg::WORD_WIDTH-1){1'b0}}, s1Data.invB};

    assign adderSum      = adderFull[aluPkg::WORD_WIDTH-1:0];
    assign adderCarry    = adderFull[aluPkg::WORD_WIDTH];
    assign carryIntoMsb  = lowPart[aluPkg::WORD_WIDTH-1];
    assign adderOverflow = carryIntoMsb ^ adderCarry;

    // sign of the difference, corrected when it overflowed
    assign sltOut = {{(aluPkg::WORD_WIDTH-1){1'b0}}, adderSum[aluPkg::WORD_WIDTH-1] ^ adderOverflow};

    assign xorOut  = s1Data.inputA ^ s1Data.inputB;
    assign nandOut = ~(s1Data.inputA & s1Data.inputB);
    assign norOut  = ~(s1Data.inputA | s1Data.inputB);

    always_comb begin
        case (s1Data.sel)
            aluPkg::SEL_ADDER: result = adderSum;
            aluPkg::SEL_XOR:   result = xorOut;
            aluPkg::SEL_SLT:   result = sltOut;
            aluPkg::SEL_NAND:  result = nandOut;
            aluPkg::SEL_NOR:   result = norOut;
            default:           result = '0;  // unused select codes
        endcase
    end

    assign useAdder = (s1Data.sel == aluPkg::SEL_ADDER);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            s2Valid <= 1'b0;
        end else begin
            s2Valid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1Valid) begin
            s2Resp.result   <= result;
            s2Resp.carryout <= useAdder & adderCarry;  // flags only mean something for add/sub
            s2Resp.overflow <= useAdder & adderOverflow;
            s2Resp.zero     <= (result == '0);
        end
    end

    // flags from a logic or slt op must never escape the stage
    flagsOnlyFromAdder: assert property (
        @(posedge clk) disable iff (!rstN)
        (s2Valid && ($past(s1Data.sel) != aluPkg::SEL_ADDER))
            |-> (!s2Resp.carryout && !s2Resp.overflow)
    ) else $error("carryout or overflow set for a non-adder result");

endmodule

`default_nettype wire

// ==== verilog/aluOperandStage.sv ====
// alu stage one, opcode decode and registered conditional operand inversion
`timescale 1ns/1ps
`default_nettype none

module aluOperandStage (
    input  wire logic             clk,
    input  wire logic             rstN,
    input  wire logic             inValid,
    input  wire aluPkg::aluReq_t  inReq,
    output logic                  s1Valid,
    output aluPkg::aluStage1_t    s1Data
);

    aluPkg::aluSel_t sel;
    logic            invA;
    logic            invB;
    aluPkg::word_t   inputA;
    aluPkg::word_t   inputB;

    // lookup table, and/or reuse nor/nand with both operands inverted
    always_comb begin
        sel  = aluPkg::SEL_ADDER;
        invA = 1'b0;
        invB = 1'b0;
        case (inReq.command)
            aluPkg::OP_ADD: sel = aluPkg::SEL_ADDER;
            aluPkg::OP_SUB: begin
                sel  = aluPkg::SEL_ADDER;
                invB = 1'b1;  // a + ~b + 1
            end
            aluPkg::OP_XOR: sel = aluPkg::SEL_XOR;
            aluPkg::OP_SLT: begin
                sel  = aluPkg::SEL_SLT;
                invB = 1'b1;
            end
            aluPkg::OP_AND: begin
                sel  = aluPkg::SEL_NOR;  // ~(~a | ~b) = a & b
                invA = 1'b1;
                invB = 1'b1;
            end
            aluPkg::OP_NAND: sel = aluPkg::SEL_NAND;
            aluPkg::OP_NOR:  sel = aluPkg::SEL_NOR;
            aluPkg::OP_OR: begin
                sel  = aluPkg::SEL_NAND;  // ~(~a & ~b) = a | b
                invA = 1'b1;
                invB = 1'b1;
            end
            default: sel = aluPkg::SEL_ADDER;
        endcase
    end

    assign inputA = invA ? ~inReq.operandA : inReq.operandA;
    assign inputB = invB ? ~inReq.operandB : inReq.operandB;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= inValid;
        end
    end

    // payload only moves with a valid request
    always_ff @(posedge clk) begin
        if (inValid) begin
            s1Data.sel    <= sel;
            s1Data.invB   <= invB;
            s1Data.inputA <= inputA;
            s1Data.inputB <= inputB;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/aluPipe.sv ====
// three stage credit flow alu, operand decode, execute, result queue
`timescale 1ns/1ps
`default_nettype none

module aluPipe (
    input  wire logic             clk,
    input  wire logic             rstN,
    input  wire logic             inValid,
    input  wire aluPkg::aluReq_t  inReq,
    input  wire logic             outCreditReturn,
    output logic                  inCredit,
    output logic                  outValid,
    output aluPkg::aluResp_t      outResp
);

    logic               s1Valid;
    aluPkg::aluStage1_t s1Data;
    logic               s2Valid;
    aluPkg::aluResp_t   s2Resp;

    // decode and invert operands
    aluOperandStage u_operandStage (
        .clk     (clk),
        .rstN    (rstN),
        .inValid (inValid),
        .inReq   (inReq),
        .s1Valid (s1Valid),
        .s1Data  (s1Data)
    );

    aluExecuteStage u_executeStage (
        .clk     (clk),
        .rstN    (rstN),
        .s1Valid (s1Valid),
        .s1Data  (s1Data),
        .s2Valid (s2Valid),
        .s2Resp  (s2Resp)
    );

    // buffering and both credit loops live here
    aluResultQueue u_resultQueue (
        .clk             (clk),
        .rstN            (rstN),
        .s2Valid         (s2Valid),
        .s2Resp          (s2Resp),
        .outCreditReturn (outCreditReturn),
        .inCredit        (inCredit),
        .outValid        (outValid),
        .outResp         (outResp)
    );

endmodule

`default_nettype wire

// ==== verilog/aluPkg.sv ====
// alu pipeline package with widths, credit sizes, opcode and select enums, stage payloads
`default_nettype none

package aluPkg;

    localparam int WORD_WIDTH   = 32;
    localparam int OP_WIDTH     = 3;
    localparam int QUEUE_DEPTH  = 4;  // result fifo slots and input credits after reset
    localparam int OUT_CREDITS  = 2;  // credits granted by downstream after reset
    localparam int CREDIT_WIDTH = 3;

    typedef logic [WORD_WIDTH-1:0]   word_t;
    typedef logic [CREDIT_WIDTH-1:0] creditCount_t;

    // and/or share the nor/nand units, see the operand stage
    typedef enum logic [OP_WIDTH-1:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_XOR  = 3'd2,
        OP_SLT  = 3'd3,
        OP_AND  = 3'd4,
        OP_NAND = 3'd5,
        OP_NOR  = 3'd6,
        OP_OR   = 3'd7
    } aluOp_t;

    // which unit drives the result
    typedef enum logic [2:0] {
        SEL_ADDER = 3'd0,
        SEL_XOR   = 3'd1,
        SEL_SLT   = 3'd2,
        SEL_NAND  = 3'd3,
        SEL_NOR   = 3'd4
    } aluSel_t;

    typedef struct packed {
        aluOp_t command;
        word_t  operandA;
        word_t  operandB;
    } aluReq_t;

    typedef struct packed {
        aluSel_t sel;
        logic    invB;    // doubles as adder carry-in
        word_t   inputA;  // operands after conditional inversion
        word_t   inputB;
    } aluStage1_t;

    typedef struct packed {
        word_t result;
        logic  carryout;
        logic  overflow;
        logic  zero;
    } aluResp_t;

endpackage

`default_nettype wire

// ==== verilog/aluResultQueue.sv ====
// alu stage three, result fifo with input credit return and output credit spending
`timescale 1ns/1ps
`default_nettype none

module aluResultQueue (
    input  wire logic             clk,
    input  wire logic             rstN,
    input  wire logic             s2Valid,
    input  wire aluPkg::aluResp_t s2Resp,
    input  wire logic             outCreditReturn,
    output logic                  inCredit,
    output logic                  outValid,
    output aluPkg::aluResp_t      outResp
);

    aluPkg::aluResp_t fifoMem [aluPkg::QUEUE_DEPTH];

    logic [$clog2(aluPkg::QUEUE_DEPTH)-1:0] wrPtr;
    logic [$clog2(aluPkg::QUEUE_DEPTH)-1:0] rdPtr;

    aluPkg::creditCount_t fifoCount;
    aluPkg::creditCount_t inOwed;      // credits still to pay upstream
    aluPkg::creditCount_t outCredits;  // credits held from downstream

    logic push;
    logic pop;
    logic payIn;

    assign push  = s2Valid;  // stages never stall, credits keep room for it
    assign pop   = (fifoCount != '0) && (outCredits != '0);
    assign payIn = (inOwed != '0);

    // fifo pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            fifoCount <= '0;
            outValid  <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fifoCount <= fifoCount + 1'b1;
                2'b01:   fifoCount <= fifoCount - 1'b1;
                default: fifoCount <= fifoCount;
            endcase
            outValid <= pop;  // result appears the cycle after the pop decision
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifoMem[wrPtr] <= s2Resp;
        end
        if (pop) begin
            outResp <= fifoMem[rdPtr];
        end
    end

    // input side, one credit pulse per cycle while anything is owed
    always_ff @(posedge clk) begin
        if (!rstN) begin
            inOwed   <= aluPkg::creditCount_t'(aluPkg::QUEUE_DEPTH);
            inCredit <= 1'b0;
        end else begin
            inCredit <= payIn;
            case ({pop, payIn})
                2'b10:   inOwed <= inOwed + 1'b1;  // slot freed, nothing paid
                2'b01:   inOwed <= inOwed - 1'b1;
                default: inOwed <= inOwed;
            endcase
        end
    end

    // output side
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outCredits <= aluPkg::creditCount_t'(aluPkg::OUT_CREDITS);
        end else begin
            case ({outCreditReturn, pop})
                2'b10:   outCredits <= outCredits + 1'b1;
                2'b01:   outCredits <= outCredits - 1'b1;
                default: outCredits <= outCredits;
            endcase
        end
    end

    // upstream sent without a credit, or a stage held more than the credits allow
    noPushWhenFull: assert property (
        @(posedge clk) disable iff (!rstN)
        push |-> (fifoCount != aluPkg::creditCount_t'(aluPkg::QUEUE_DEPTH))
    ) else $error("push into a full result fifo");

    // downstream returned more credits than it granted
    outCreditsBounded: assert property (
        @(posedge clk) disable iff (!rstN)
        outCredits <= aluPkg::creditCount_t'(aluPkg::OUT_CREDITS)
    ) else $error("output credit count above grant");

    outValidHasCredit: assert property (
        @(posedge clk) disable iff (!rstN)
        outValid |-> ($past(outCredits) != '0)
    ) else $error("result sent without an output credit");

endmodule

`default_nettype wire
